//--- project.f
hw/eth_pkg.sv
hw/stat_pkg.sv
hw/eth_stat_collect.sv
hw/stat_arb_mux.sv
hw/stat_counter.sv
hw/stats_core.sv
verification/stats_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TB_TOP     ?= stats_core_tb
RTL_TOP    ?= stats_core
FILE_LIST  ?= project.f
BUILD_DIR  ?= build
LOG        ?= sim.log
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILE_LIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/stats_core_tb.sv
// Self-checking testbench for stats_core that the Makefile builds from project.f
`timescale 1ns/1ps

module stats_core_tb;

    localparam int CLK_PERIOD = 100;
    localparam int EVT_BITS = eth_pkg::ETH_CH_COUNT * eth_pkg::ETH_EVT_COUNT;
    localparam int RD_WAIT = 8;
    localparam int READ_CYCLES = RD_WAIT + 2;
    localparam int READ_ALL_CYCLES = stat_pkg::STAT_COUNT * READ_CYCLES;
    // Channel 2 rx_pkt_good
    localparam int BURST_ID = 2 * eth_pkg::ETH_EVT_COUNT + 1;
    localparam int TOTAL_CYCLES = 19 + READ_ALL_CYCLES
        + (2 * EVT_BITS + 20 + READ_ALL_CYCLES)
        + (200 + 100 + READ_ALL_CYCLES)
        + (400 + 100 + READ_ALL_CYCLES)
        + (300 + 40 + READ_CYCLES);

    logic                              clk = 1'b0;
    logic                              rst;
    logic [EVT_BITS-1:0]               evt_bits;
    eth_pkg::eth_evt_t                 eth_evt [eth_pkg::ETH_CH_COUNT];
    logic                              rd_req;
    logic [stat_pkg::STAT_ID_W-1:0]    rd_addr;
    logic                              rd_valid;
    logic [stat_pkg::STAT_COUNT_W-1:0] rd_data;

    // Expected counts indexed by channel * ETH_EVT_COUNT + event
    logic [stat_pkg::STAT_COUNT_W-1:0] ref_count [stat_pkg::STAT_COUNT];
    logic [15:0] lfsr;
    int data_errors;
    int timing_errors;
    int missing_reads;

    // Event index follows member order, tx_pkt_good is index 0
    function automatic eth_pkg::eth_evt_t evt_from_bits(
        input logic [eth_pkg::ETH_EVT_COUNT-1:0] bits);
        eth_pkg::eth_evt_t evt;
        evt.tx_pkt_good = bits[0];
        evt.rx_pkt_good = bits[1];
        evt.rx_pkt_bad = bits[2];
        evt.rx_err_fcs = bits[3];
        return evt;
    endfunction

    for (genvar ch = 0; ch < eth_pkg::ETH_CH_COUNT; ch++) begin : g_evt
        assign eth_evt[ch] = evt_from_bits(
            evt_bits[ch*eth_pkg::ETH_EVT_COUNT +: eth_pkg::ETH_EVT_COUNT]);
    end

    stats_core DUT (
        .clk_125mhz_i(clk),
        .rst_i(rst),
        .eth_evt_i(eth_evt),
        .rd_req_i(rd_req),
        .rd_addr_i(rd_addr),
        .rd_valid_o(rd_valid),
        .rd_data_o(rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Read valid exactly two cycles after each strobe and at no other time
    assert property (@(posedge clk) disable iff (rst) rd_valid == $past(rd_req, 2))
    else begin
        timing_errors++;
        $display("Read valid did not follow the read strobe by two cycles at %0t", $time);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    // One clock of event pulses that the model also counts
    task automatic drive_cycle(input logic [EVT_BITS-1:0] bits);
        @(posedge clk);
        evt_bits <= bits;
        for (int i = 0; i < EVT_BITS; i++) begin
            ref_count[i] = ref_count[i] + stat_pkg::STAT_COUNT_W'(bits[i]);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive_cycle('0);
            rd_req <= 1'b0;
        end
    endtask

    task automatic read_check(input int id, input string name);
        int waited;
        logic got;
        waited = 0;
        got = 1'b0;
        @(posedge clk);
        rd_req <= 1'b1;
        rd_addr <= stat_pkg::STAT_ID_W'(id);
        @(posedge clk);
        rd_req <= 1'b0;
        while (!got && waited < RD_WAIT) begin
            @(negedge clk);
            waited++;
            if (rd_valid) begin
                got = 1'b1;
                assert (rd_data == ref_count[id])
                else begin
                    data_errors++;
                    $display("ERROR %s counter %0d expected %0d actual %0d",
                             name, id, ref_count[id], rd_data);
                end
            end
        end
        assert (got)
        else begin
            missing_reads++;
            $display("No read response for counter %0d in %s", id, name);
        end
    endtask

    task automatic read_all(input string name);
        for (int id = 0; id < stat_pkg::STAT_COUNT; id++) begin
            read_check(id, name);
        end
    endtask

    initial begin
        logic [EVT_BITS-1:0] bits;
        logic [stat_pkg::STAT_ID_W-1:0] addr;
        logic b0;
        logic b1;
        rst = 1'b1;
        evt_bits = '0;
        rd_req = 1'b0;
        rd_addr = '0;
        lfsr = 16'd78;
        data_errors = 0;
        timing_errors = 0;
        missing_reads = 0;
        for (int i = 0; i < stat_pkg::STAT_COUNT; i++) begin
            ref_count[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // RAM zero sweep runs here
        repeat (16) @(posedge clk);

        read_all("reset_zero");

        for (int i = 0; i < EVT_BITS; i++) begin
            drive_cycle(EVT_BITS'(1) << i);
            idle(1);
        end
        idle(20);
        read_all("single_event");

        repeat (200) drive_cycle('1);
        idle(100);
        read_all("all_channels_at_once");

        for (int c = 0; c < 400; c++) begin
            for (int i = 0; i < EVT_BITS; i++) begin
                take_bit(bits[i]);
            end
            take_bit(b0);
            take_bit(b1);
            for (int i = 0; i < stat_pkg::STAT_ID_W; i++) begin
                take_bit(addr[i]);
            end
            drive_cycle(bits);
            rd_req <= b0 && b1;
            rd_addr <= addr;
        end
        idle(100);
        read_all("reads_under_load");

        // Counter 9 gains 300 on top of earlier tests
        repeat (300) drive_cycle(EVT_BITS'(1) << BURST_ID);
        idle(40);
        read_check(BURST_ID, "same_counter_burst");

        repeat (4) @(posedge clk);
        $display("Summary: %0d data errors, %0d timing errors, %0d missing reads",
                 data_errors, timing_errors, missing_reads);
        if (data_errors == 0 && timing_errors == 0 && missing_reads == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Twice the summed length of all tests
    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout, the tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- hw/stats_core.sv
// Statistics top level taking per-channel event pulses and serving counter reads to the host
`timescale 1ns/1ps

module stats_core (
    input  logic                              clk_125mhz_i,
    input  logic                              rst_i,
    input  eth_pkg::eth_evt_t                 eth_evt_i [eth_pkg::ETH_CH_COUNT],
    input  logic                              rd_req_i,
    input  logic [stat_pkg::STAT_ID_W-1:0]    rd_addr_i,
    output logic                              rd_valid_o,
    output logic [stat_pkg::STAT_COUNT_W-1:0] rd_data_o
);

    // Collector streams into the arbiter
    stat_pkg::stat_upd_t               ch_upd [eth_pkg::ETH_CH_COUNT];
    logic [eth_pkg::ETH_CH_COUNT-1:0]  ch_upd_valid;
    logic [eth_pkg::ETH_CH_COUNT-1:0]  ch_upd_ready;

    // Merged stream into the counter bank
    stat_pkg::stat_upd_t mux_upd;
    logic                mux_upd_valid;
    logic                mux_upd_ready;

    // Channel n owns counters n*ETH_EVT_COUNT and up
    generate
        for (genvar ch = 0; ch < eth_pkg::ETH_CH_COUNT; ch++) begin : g_ch
            eth_stat_collect #(
                .STAT_ID_BASE(ch * eth_pkg::ETH_EVT_COUNT)
            ) collect_inst (
                .clk_125mhz_i(clk_125mhz_i),
                .rst_i(rst_i),
                .evt_i(eth_evt_i[ch]),
                .upd_o(ch_upd[ch]),
                .upd_valid_o(ch_upd_valid[ch]),
                .upd_ready_i(ch_upd_ready[ch])
            );
        end
    endgenerate

    stat_arb_mux #(
        .S_COUNT(eth_pkg::ETH_CH_COUNT),
        .T(stat_pkg::stat_upd_t)
    ) arb_inst (
        .clk_125mhz_i(clk_125mhz_i),
        .rst_i(rst_i),
        .s_data_i(ch_upd),
        .s_valid_i(ch_upd_valid),
        .s_ready_o(ch_upd_ready),
        .m_data_o(mux_upd),
        .m_valid_o(mux_upd_valid),
        .m_ready_i(mux_upd_ready)
    );

    stat_counter counter_inst (
        .clk_125mhz_i(clk_125mhz_i),
        .rst_i(rst_i),
        .upd_i(mux_upd),
        .upd_valid_i(mux_upd_valid),
        .upd_ready_o(mux_upd_ready),
        .rd_req_i(rd_req_i),
        .rd_addr_i(rd_addr_i),
        .rd_valid_o(rd_valid_o),
        .rd_data_o(rd_data_o)
    );

endmodule

//--- hw/stat_counter.sv
// Counter bank in RAM that adds stat updates and serves host reads two cycles after the strobe
`timescale 1ns/1ps

module stat_counter (
    input  logic                             clk_125mhz_i,
    input  logic                             rst_i,
    input  stat_pkg::stat_upd_t              upd_i,
    input  logic                             upd_valid_i,
    output logic                             upd_ready_o,
    input  logic                             rd_req_i,
    input  logic [stat_pkg::STAT_ID_W-1:0]   rd_addr_i,
    output logic                             rd_valid_o,
    output logic [stat_pkg::STAT_COUNT_W-1:0] rd_data_o
);

    // Counter RAM with one read port shared by host and updates
    logic [stat_pkg::STAT_COUNT_W-1:0] ram [stat_pkg::STAT_COUNT];
    logic [stat_pkg::STAT_ID_W-1:0]    ram_rd_addr;
    logic [stat_pkg::STAT_COUNT_W-1:0] ram_rd_q;
    logic                              ram_wr_en;
    logic [stat_pkg::STAT_ID_W-1:0]    ram_wr_addr;
    logic [stat_pkg::STAT_COUNT_W-1:0] ram_wr_data;

    // Zero sweep after reset
    logic                           clr_active_q;
    logic [stat_pkg::STAT_ID_W-1:0] clr_addr_q;

    logic upd_accept;

    // Stage 1 holds the access whose RAM data is arriving
    logic                              s1_upd_q;
    logic                              s1_rd_q;
    logic [stat_pkg::STAT_ID_W-1:0]    s1_id_q;
    logic [stat_pkg::STAT_INC_W-1:0]   s1_inc_q;
    logic [stat_pkg::STAT_COUNT_W-1:0] s1_cur;

    // Stage 2 is the write in flight, stage 3 the write just landed
    logic                              s2_valid_q;
    logic [stat_pkg::STAT_ID_W-1:0]    s2_id_q;
    logic [stat_pkg::STAT_COUNT_W-1:0] s2_sum_q;
    logic                              s3_valid_q;
    logic [stat_pkg::STAT_ID_W-1:0]    s3_id_q;
    logic [stat_pkg::STAT_COUNT_W-1:0] s3_sum_q;

    logic                              rd_valid_q;
    logic [stat_pkg::STAT_COUNT_W-1:0] rd_data_q;

    // Host reads win the read port
    assign upd_ready_o = !rd_req_i;
    assign upd_accept = upd_valid_i && !rd_req_i;
    assign ram_rd_addr = rd_req_i ? rd_addr_i : upd_i.id;

    assign ram_wr_en = clr_active_q || s2_valid_q;
    assign ram_wr_addr = clr_active_q ? clr_addr_q : s2_id_q;
    assign ram_wr_data = clr_active_q ? '0 : s2_sum_q;

    always_ff @(posedge clk_125mhz_i) begin
        if (ram_wr_en) begin
            ram[ram_wr_addr] <= ram_wr_data;
        end
        ram_rd_q <= ram[ram_rd_addr];
    end

    // Takes STAT_COUNT cycles once reset drops
    always_ff @(posedge clk_125mhz_i) begin
        if (rst_i) begin
            clr_active_q <= 1'b1;
            clr_addr_q <= '0;
        end else if (clr_active_q) begin
            clr_addr_q <= clr_addr_q + 1'b1;
            if (clr_addr_q == stat_pkg::STAT_ID_W'(stat_pkg::STAT_COUNT - 1)) begin
                clr_active_q <= 1'b0;
            end
        end
    end

    // Newest matching in-flight sum beats the RAM data
    always_comb begin
        s1_cur = ram_rd_q;
        if (s2_valid_q && s2_id_q == s1_id_q) begin
            s1_cur = s2_sum_q;
        end else if (s3_valid_q && s3_id_q == s1_id_q) begin
            s1_cur = s3_sum_q;
        end
    end

    always_ff @(posedge clk_125mhz_i) begin
        if (rst_i) begin
            s1_upd_q <= 1'b0;
            s1_rd_q <= 1'b0;
            s2_valid_q <= 1'b0;
            s3_valid_q <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            s1_upd_q <= upd_accept;
            s1_rd_q <= rd_req_i;
            s2_valid_q <= s1_upd_q;
            s3_valid_q <= s2_valid_q;
            rd_valid_q <= s1_rd_q;
        end
    end

    always_ff @(posedge clk_125mhz_i) begin
        s1_id_q <= ram_rd_addr;
        s1_inc_q <= upd_i.inc;
        s2_id_q <= s1_id_q;
        s2_sum_q <= s1_cur + stat_pkg::STAT_COUNT_W'(s1_inc_q);
        s3_id_q <= s2_id_q;
        s3_sum_q <= s2_sum_q;
        rd_data_q <= s1_cur;
    end

    assign rd_valid_o = rd_valid_q;
    assign rd_data_o = rd_data_q;

endmodule

//--- hw/stat_arb_mux.sv
// Round-robin merge of several valid/ready streams into one registered output stream
`timescale 1ns/1ps

module stat_arb_mux #(
    parameter int  S_COUNT = 4,
    parameter type T       = logic [7:0]
) (
    input  logic               clk_125mhz_i,
    input  logic               rst_i,
    input  T                   s_data_i [S_COUNT],
    input  logic [S_COUNT-1:0] s_valid_i,
    output logic [S_COUNT-1:0] s_ready_o,
    output T                   m_data_o,
    output logic               m_valid_o,
    input  logic               m_ready_i
);

    // Input with the highest priority next round
    logic [$clog2(S_COUNT)-1:0] prio_q;

    logic [$clog2(S_COUNT)-1:0] grant_idx;
    logic                       grant_found;
    logic                       out_free;

    T     m_data_q;
    logic m_valid_q;

    // Lowest valid input counting up from the priority pointer
    always_comb begin
        logic [$clog2(S_COUNT)-1:0] idx;
        grant_found = 1'b0;
        grant_idx = prio_q;
        for (int i = 0; i < S_COUNT; i++) begin
            idx = $clog2(S_COUNT)'((int'(prio_q) + i) % S_COUNT);
            if (!grant_found && s_valid_i[idx]) begin
                grant_found = 1'b1;
                grant_idx = idx;
            end
        end
    end

    // Output register can take a new item this cycle
    assign out_free = !m_valid_q || m_ready_i;

    always_comb begin
        s_ready_o = '0;
        if (grant_found && out_free) begin
            s_ready_o[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_125mhz_i) begin
        if (rst_i) begin
            m_valid_q <= 1'b0;
            prio_q <= '0;
        end else if (out_free) begin
            m_valid_q <= grant_found;
            // Winner drops to lowest priority
            if (grant_found) begin
                prio_q <= $clog2(S_COUNT)'((int'(grant_idx) + 1) % S_COUNT);
            end
        end
    end

    always_ff @(posedge clk_125mhz_i) begin
        if (out_free && grant_found) begin
            m_data_q <= s_data_i[grant_idx];
        end
    end

    assign m_data_o = m_data_q;
    assign m_valid_o = m_valid_q;

endmodule

//--- hw/eth_stat_collect.sv
// Collector that turns one channel's event pulses into stat update items for the arbiter
`timescale 1ns/1ps

module eth_stat_collect #(
    parameter int STAT_ID_BASE = 0
) (
    input  logic                clk_125mhz_i,
    input  logic                rst_i,
    input  eth_pkg::eth_evt_t   evt_i,
    output stat_pkg::stat_upd_t upd_o,
    output logic                upd_valid_o,
    input  logic                upd_ready_i
);

    // Pulses in counter order, bit n is event index n
    logic [eth_pkg::ETH_EVT_COUNT-1:0] evt_vec;

    logic [stat_pkg::STAT_INC_W-1:0]   pend_q [eth_pkg::ETH_EVT_COUNT];
    logic [eth_pkg::ETH_EVT_IDX_W-1:0] ptr_q;

    stat_pkg::stat_upd_t out_q;
    logic                out_valid_q;

    logic [eth_pkg::ETH_EVT_IDX_W-1:0] sel_idx;
    logic                              sel_found;
    logic                              load;

    assign evt_vec = {evt_i.rx_err_fcs, evt_i.rx_pkt_bad, evt_i.rx_pkt_good, evt_i.tx_pkt_good};

    // First nonzero accumulator at or after the rotating pointer
    always_comb begin
        logic [eth_pkg::ETH_EVT_IDX_W-1:0] idx;
        sel_found = 1'b0;
        sel_idx = ptr_q;
        for (int i = 0; i < eth_pkg::ETH_EVT_COUNT; i++) begin
            idx = eth_pkg::ETH_EVT_IDX_W'((int'(ptr_q) + i) % eth_pkg::ETH_EVT_COUNT);
            if (!sel_found && pend_q[idx] != '0) begin
                sel_found = 1'b1;
                sel_idx = idx;
            end
        end
    end

    // Output slot refills when empty or when its item is taken
    assign load = !out_valid_q || upd_ready_i;

    always_ff @(posedge clk_125mhz_i) begin
        if (rst_i) begin
            for (int e = 0; e < eth_pkg::ETH_EVT_COUNT; e++) begin
                pend_q[e] <= '0;
            end
            ptr_q <= '0;
            out_valid_q <= 1'b0;
        end else begin
            for (int e = 0; e < eth_pkg::ETH_EVT_COUNT; e++) begin
                if (load && sel_found && int'(sel_idx) == e) begin
                    // A pulse in the hand-off cycle starts the next count
                    pend_q[e] <= stat_pkg::STAT_INC_W'(evt_vec[e]);
                end else if (evt_vec[e] && pend_q[e] != '1) begin
                    // Holds at all ones instead of wrapping
                    pend_q[e] <= pend_q[e] + 1'b1;
                end
            end
            if (load) begin
                out_valid_q <= sel_found;
                if (sel_found) begin
                    ptr_q <= eth_pkg::ETH_EVT_IDX_W'((int'(sel_idx) + 1) % eth_pkg::ETH_EVT_COUNT);
                end
            end
        end
    end

    // Item stays put while the arbiter stalls
    always_ff @(posedge clk_125mhz_i) begin
        if (load && sel_found) begin
            out_q.id  <= stat_pkg::STAT_ID_W'(STAT_ID_BASE) + stat_pkg::STAT_ID_W'(sel_idx);
            out_q.inc <= pend_q[sel_idx];
        end
    end

    assign upd_o = out_q;
    assign upd_valid_o = out_valid_q;

endmodule

//--- hw/stat_pkg.sv
// Statistics stream and counter bank definitions shared by collectors and the counter RAM
package stat_pkg;

    // Counter id width
    localparam int STAT_ID_W = 4;

    // Largest increment carried by one update item
    localparam int STAT_INC_W = 8;

    // Width of each stored counter
    localparam int STAT_COUNT_W = 32;

    // Counters in the bank, one per id
    localparam int STAT_COUNT = 2 ** STAT_ID_W;

    // One update item on the stat stream
    // Adds inc to the counter selected by id
    typedef struct packed {
        logic [STAT_ID_W-1:0]  id;
        logic [STAT_INC_W-1:0] inc;
    } stat_upd_t;

endpackage

//--- hw/eth_pkg.sv
// Ethernet channel definitions used by the event collectors and the stats top level
package eth_pkg;

    // Number of MAC channels on the board
    localparam int ETH_CH_COUNT = 4;

    // Event kinds per channel
    // Also the stride between the counter blocks of two channels
    localparam int ETH_EVT_COUNT = 4;

    // Width of an event index within one channel
    localparam int ETH_EVT_IDX_W = 2;

    // Per-frame event pulses from one channel
    // Event index follows member order, so tx_pkt_good is index 0
    typedef struct packed {
        // Frame sent without error
        logic tx_pkt_good;
        // Frame received without error
        logic rx_pkt_good;
        // Frame received with any error
        logic rx_pkt_bad;
        // Receive FCS mismatch, also flagged as rx_pkt_bad
        logic rx_err_fcs;
    } eth_evt_t;

endpackage
